//--- mbesm_mmu.f
+incdir+logic
logic/mbesm_pkg.sv
logic/mode_reg.sv
logic/page_translate.sv
logic/tag_check.sv
logic/mbesm_mmu.sv
verif/mmu_checker.sv
verif/tb_mbesm_mmu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mbesm_mmu
FILELIST  ?= mbesm_mmu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q '>>> PASS' $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_mbesm_mmu.sv
// Testbench top for the MMU with clock, reset, stimulus table,
// drive loop and watchdog

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module tb_mbesm_mmu
    import mbesm_pkg::*;
();

localparam logic [2:0] SEL_NONE   = 3'd0;
localparam logic [2:0] SEL_RR     = 3'd1;
localparam logic [2:0] SEL_PHYSAD = 3'd2;
localparam logic [2:0] SEL_MAP    = 3'd3;
localparam logic [2:0] SEL_ACCESS = 3'd4;
localparam logic [2:0] SEL_INT    = 3'd5;   // {o_int, o_int_vect}

localparam logic [9:0] PG_A   = 10'h2A7;    // Native page
localparam logic [9:0] PG_B   = 10'h3C6;    // Low 5 bits give PG_E
localparam logic [9:0] PG_E   = 10'h006;    // Emulation page
localparam logic [9:0] OFFS_A = 10'h155;
localparam logic [9:0] OFFS_B = 10'h0E9;

typedef struct packed {
    mmu_op_t     op;
    logic [31:0] data;
    arb_op_t     arb;
    mem_tag_t    tag;
    logic [2:0]  sel;   // Output under check
    logic [31:0] exp;
} step_t;

logic                                   clk = 1'b0;
logic                                   reset = 1'b1;
mmu_op_t                                i_op;
logic [`MBESM_VADDR_W-1:0]              i_data;
arb_op_t                                i_arb_op;
mem_tag_t                               i_tag;
mode_reg_t                              o_rr;
logic [`MBESM_PAGE_W+`MBESM_OFFS_W-1:0] o_physad;
logic [`MBESM_MAP_W-1:0]                o_map_rdata;
page_access_t                           o_access;
logic                                   o_int;
int_vect_t                              o_int_vect;
logic                                   chk_en;
logic [2:0]                             chk_sel;
logic [31:0]                            chk_exp;
int                                     chk_id;
int                                     pass_cnt;
int                                     fail_cnt;
int                                     n_checks = 0;
int                                     seed = 32'hb69c;
logic                                   table_ready = 1'b0;
step_t                                  steps [$];

mbesm_mmu dut (.*);

mmu_checker mmu_chk (
    .clk         (clk),
    .i_rr        (o_rr),
    .i_physad    (o_physad),
    .i_map_rdata (o_map_rdata),
    .i_access    (o_access),
    .i_int       (o_int),
    .i_int_vect  (o_int_vect),
    .i_chk_en    (chk_en),
    .i_chk_sel   (chk_sel),
    .i_chk_exp   (chk_exp),
    .i_chk_id    (chk_id),
    .o_pass_cnt  (pass_cnt),
    .o_fail_cnt  (fail_cnt)
);

always #5 clk = ~clk;

task automatic add_step(input mmu_op_t op, input logic [31:0] data, input logic [2:0] sel,
                        input logic [31:0] exp, input arb_op_t arb = ARB_IDLE,
                        input logic [7:0] tag = 8'h00);
    steps.push_back('{op, data, arb, tag, sel, exp});
    if (sel != SEL_NONE)
        n_checks++;
endtask

// Event, flag and vector two edges later, then the flag cleared
task automatic tag_raises(input mmu_op_t op, input logic [7:0] tag, input int_vect_t vect);
    add_step(op, 32'h0, SEL_NONE, 32'h0, ARB_IDLE, tag);
    add_step(NOP, 32'h0, SEL_INT, {26'h0, 1'b1, vect});
    add_step(CLEAR_INT, 32'h0, SEL_INT, {26'h0, 1'b0, vect});
endtask

task automatic tag_silent(input mmu_op_t op, input logic [7:0] tag, input int_vect_t held);
    add_step(op, 32'h0, SEL_NONE, 32'h0, ARB_IDLE, tag);
    add_step(NOP, 32'h0, SEL_INT, {26'h0, 1'b0, held});   // Vector untouched
endtask

task automatic build_table();
    logic [31:0] map_a;
    logic [31:0] map_b;
    logic [31:0] map_c;
    map_a = $random(seed);
    map_b = $random(seed);
    map_c = $random(seed);
    // ----------------------------------------
    // Reset state and mode register
    add_step(NOP, 32'h0, SEL_RR, 32'h0);
    add_step(NOP, 32'h0, SEL_INT, 32'h0);
    add_step(LOAD_RR, 32'hA5C3_0F96, SEL_RR, 32'hA5C3_0F96);
    add_step(LOAD_RR, 32'h0, SEL_RR, 32'h0);
    // Native translation and no_paging (bit 26)
    add_step(LOAD_VADDR, {12'h0, PG_A, OFFS_A}, SEL_NONE, 32'h0);
    add_step(WRITE_MAP, map_a, SEL_MAP, {12'h0, map_a[19:0]});
    add_step(NOP, 32'h0, SEL_PHYSAD, {12'h0, map_a[19:10], OFFS_A});
    add_step(LOAD_RR, 32'h0400_0000, SEL_PHYSAD, {12'h0, PG_A, OFFS_A});
    add_step(LOAD_RR, 32'h0, SEL_PHYSAD, {12'h0, map_a[19:10], OFFS_A});
    // Emulation mode uses address bits 14:10
    add_step(LOAD_VADDR, {12'h0, PG_E, OFFS_B}, SEL_NONE, 32'h0);
    add_step(WRITE_MAP, map_b, SEL_MAP, {12'h0, map_b[19:0]});
    add_step(LOAD_VADDR, {12'h0, PG_B, OFFS_B}, SEL_NONE, 32'h0);
    add_step(WRITE_MAP, map_c, SEL_MAP, {12'h0, map_c[19:0]});
    add_step(NOP, 32'h0, SEL_PHYSAD, {12'h0, map_c[19:10], OFFS_B});
    add_step(SET_ER, 32'h0, SEL_PHYSAD, {12'h0, map_b[19:10], OFFS_B});
    add_step(SET_NR, 32'h0, SEL_PHYSAD, {12'h0, map_c[19:10], OFFS_B});
    // ----------------------------------------
    // Used/dirty bits of page map_c[19:10]
    add_step(BUS_REQ, 32'h0, SEL_NONE, 32'h0, CCRD);
    add_step(WRITE_ACCESS, 32'h0, SEL_ACCESS, 32'h0);
    add_step(BUS_REQ, 32'h0, SEL_ACCESS, 32'h1, DRD);       // Read sets used only
    add_step(BUS_REQ, 32'h0, SEL_ACCESS, 32'h3, DWR);
    add_step(WRITE_ACCESS, 32'h4, SEL_ACCESS, 32'h2);
    add_step(WRITE_ACCESS, 32'h2, SEL_ACCESS, 32'h1);
    add_step(WRITE_ACCESS, 32'h0, SEL_ACCESS, 32'h0);
    add_step(BUS_REQ, 32'h0, SEL_ACCESS, 32'h3, BTRWR);
    // ----------------------------------------
    // One rule per tag
    tag_silent(FETCH_DONE, 8'h01, INT_NONE);                // Clean instruction word
    tag_raises(FETCH_DONE, 8'h81, INT_PINT_CMD);
    tag_raises(LOAD_DONE, 8'h80, INT_PINT_OPND);
    tag_raises(LOAD_DONE, 8'h04, INT_RD_PROT);
    tag_raises(FETCH_DONE, 8'h00, INT_CMD_CHECK);
    tag_raises(FETCH_DONE, 8'h11, INT_FETCH_PROT);
    tag_silent(FETCH_DONE, 8'h21, INT_FETCH_PROT);          // Nojump without jump flag
    add_step(LOAD_RR, 32'h2000_0000, SEL_RR, 32'h2000_0000);
    tag_raises(FETCH_DONE, 8'h21, INT_JUMP_PROT);
    add_step(LOAD_RR, 32'h0, SEL_RR, 32'h0);
    tag_raises(FETCH_DONE, 8'h03, INT_BAD_ACC);
    tag_raises(LOAD_DONE, 8'h02, INT_BAD_OPND);
    // Priority among several rules
    tag_raises(FETCH_DONE, 8'h90, INT_PINT_CMD);
    tag_raises(LOAD_DONE, 8'h86, INT_PINT_OPND);
    tag_raises(FETCH_DONE, 8'h12, INT_CMD_CHECK);
    // Masks no_progtag and no_rtag in turn and then all four
    add_step(LOAD_RR, 32'h0001_0000, SEL_RR, 32'h0001_0000);
    tag_raises(LOAD_DONE, 8'h86, INT_RD_PROT);
    tag_raises(FETCH_DONE, 8'h83, INT_BAD_ACC);
    add_step(LOAD_RR, 32'h0001_4000, SEL_RR, 32'h0001_4000);
    tag_raises(LOAD_DONE, 8'h86, INT_BAD_OPND);
    add_step(LOAD_RR, 32'h0001_E000, SEL_RR, 32'h0001_E000);
    tag_silent(LOAD_DONE, 8'h86, INT_BAD_OPND);
    tag_silent(FETCH_DONE, 8'h83, INT_BAD_OPND);
    add_step(LOAD_RR, 32'h0, SEL_RR, 32'h0);
    // Accumulator in emulation mode
    add_step(LOAD_ACC_TAG, 32'h2, SEL_NONE, 32'h0);
    tag_silent(FETCH_DONE, 8'h03, INT_BAD_OPND);
    tag_raises(FETCH_DONE, 8'h01, INT_BAD_ACC);
    // Back-to-back events overwrite the vector
    add_step(FETCH_DONE, 32'h0, SEL_NONE, 32'h0, ARB_IDLE, 8'h00);
    add_step(LOAD_DONE, 32'h0, SEL_INT, {26'h0, 1'b1, INT_CMD_CHECK}, ARB_IDLE, 8'h80);
    add_step(NOP, 32'h0, SEL_INT, {26'h0, 1'b1, INT_PINT_OPND});
endtask

initial begin
    i_op     = NOP;
    i_data   = '0;
    i_arb_op = ARB_IDLE;
    i_tag    = '0;
    chk_en   = 1'b0;
    chk_sel  = SEL_NONE;
    chk_exp  = '0;
    chk_id   = 0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (steps[k]) begin
        i_op     = steps[k].op;
        i_data   = steps[k].data;
        i_arb_op = steps[k].arb;
        i_tag    = steps[k].tag;
        chk_en   = (steps[k].sel != SEL_NONE);
        chk_sel  = steps[k].sel;
        chk_exp  = steps[k].exp;
        chk_id   = k;
        @(posedge clk);
        #1;                                 // Drive just after the edge
    end
    i_op   = NOP;
    chk_en = 1'b0;
    repeat (2) @(posedge clk);              // Last comparison lands
    $display("%0d of %0d checks passed, %0d failed", pass_cnt, n_checks, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n_checks)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
end

// Watchdog allows four cycles per step plus margin
initial begin
    wait (table_ready);
    repeat (steps.size() * 4 + 100) @(posedge clk);
    $display("Run timed out before the stimulus table finished");
    $display(">>> FAIL");
    $finish;
end

endmodule

//--- verif/mmu_checker.sv
// Output checker for the MMU testbench: latches each check request,
// compares the DUT output mid-cycle and counts the results

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module mmu_checker
    import mbesm_pkg::*;
(
    input  logic                                    clk,
    input  mode_reg_t                               i_rr,
    input  logic [`MBESM_PAGE_W+`MBESM_OFFS_W-1:0]  i_physad,
    input  logic [`MBESM_MAP_W-1:0]                 i_map_rdata,
    input  page_access_t                            i_access,
    input  logic                                    i_int,
    input  int_vect_t                               i_int_vect,
    input  logic                                    i_chk_en,   // Check wanted this cycle
    input  logic [2:0]                              i_chk_sel,  // Output under check
    input  logic [31:0]                             i_chk_exp,
    input  int                                      i_chk_id,
    output int                                      o_pass_cnt,
    output int                                      o_fail_cnt
);

localparam logic [2:0] SEL_RR     = 3'd1;
localparam logic [2:0] SEL_PHYSAD = 3'd2;
localparam logic [2:0] SEL_MAP    = 3'd3;
localparam logic [2:0] SEL_ACCESS = 3'd4;

logic        pend_en = 1'b0;    // Request of the step just applied
logic [2:0]  pend_sel;
logic [31:0] pend_exp;
int          pend_id;
logic [31:0] actual;            // Selected DUT output, zero-extended
int          pass_cnt = 0;
int          fail_cnt = 0;

assign o_pass_cnt = pass_cnt;
assign o_fail_cnt = fail_cnt;

function automatic string out_name(input logic [2:0] sel);
    case (sel)
        SEL_RR:     return "o_rr";
        SEL_PHYSAD: return "o_physad";
        SEL_MAP:    return "o_map_rdata";
        SEL_ACCESS: return "o_access";
        default:    return "{o_int, o_int_vect}";
    endcase
endfunction

always_comb begin
    case (pend_sel)
        SEL_RR:     actual = i_rr;
        SEL_PHYSAD: actual = {12'h0, i_physad};
        SEL_MAP:    actual = {12'h0, i_map_rdata};
        SEL_ACCESS: actual = {30'h0, i_access};
        default:    actual = {26'h0, i_int, i_int_vect};   // Flag above vector
    endcase
end

// ----------------------------------------
// Step applied at this edge, result settles before the falling edge
always @(posedge clk) begin
    pend_en  <= i_chk_en;
    pend_sel <= i_chk_sel;
    pend_exp <= i_chk_exp;
    pend_id  <= i_chk_id;
end

always @(negedge clk) begin
    if (pend_en) begin
        if (actual !== pend_exp) begin
            $display("** Error at %0t ns: step %0d %s expected %h, got %h",
                     $time, pend_id, out_name(pend_sel), pend_exp, actual);
            fail_cnt++;
        end else begin
            $display("step %0d %s = %h ok", pend_id, out_name(pend_sel), actual);
            pass_cnt++;
        end
    end
end

endmodule

//--- logic/mbesm_mmu.sv
// Top level: mode register, page translation and tag checks

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module mbesm_mmu
    import mbesm_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  mmu_op_t                                 i_op,
    input  logic [`MBESM_VADDR_W-1:0]               i_data,
    input  arb_op_t                                 i_arb_op,
    input  mem_tag_t                                i_tag,
    output mode_reg_t                               o_rr,
    output logic [`MBESM_PAGE_W+`MBESM_OFFS_W-1:0]  o_physad,
    output logic [`MBESM_MAP_W-1:0]                 o_map_rdata,
    output page_access_t                            o_access,
    output logic                                    o_int,
    output int_vect_t                               o_int_vect
);

logic mode_besm6;   // Emulation mode
logic acc_besm6;    // Accumulator emulation tag

mode_reg mode (
    .clk          (clk),
    .reset        (reset),
    .i_op         (i_op),
    .i_data       (i_data),
    .i_tag        (i_tag),
    .o_mode       (o_rr),
    .o_mode_besm6 (mode_besm6),
    .o_acc_besm6  (acc_besm6)
);

page_translate xlate (
    .clk          (clk),
    .reset        (reset),
    .i_op         (i_op),
    .i_arb_op     (i_arb_op),
    .i_data       (i_data),
    .i_no_paging  (o_rr.no_paging),
    .i_mode_besm6 (mode_besm6),
    .o_physad     (o_physad),
    .o_map_rdata  (o_map_rdata),
    .o_access     (o_access)
);

tag_check tags (
    .clk          (clk),
    .reset        (reset),
    .i_op         (i_op),
    .i_tag        (i_tag),
    .i_mode       (o_rr),
    .i_acc_besm6  (acc_besm6),
    .o_int        (o_int),
    .o_int_vect   (o_int_vect)
);

endmodule

//--- logic/tag_check.sv
// Tag capture after fetch/load and prioritized interrupt
// flag and vector

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module tag_check
    import mbesm_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  mmu_op_t   i_op,
    input  mem_tag_t  i_tag,
    input  mode_reg_t i_mode,
    input  logic      i_acc_besm6,
    output logic      o_int,
    output int_vect_t o_int_vect
);

logic                    fetch_q;   // Fetch completed last cycle
logic                    load_q;    // Load completed last cycle
logic [`MBESM_TAG_W-1:0] tag_q;     // Captured tag
mem_tag_t                tag;
logic                    hit;       // Some check fired
int_vect_t               vect;      // Highest-priority vector

// ----------------------------------------
// Stage 1, capture
always_ff @(posedge clk) begin
    if (reset) begin
        fetch_q <= 1'b0;
        load_q  <= 1'b0;
    end else begin
        fetch_q <= (i_op == FETCH_DONE);
        load_q  <= (i_op == LOAD_DONE);
    end
end

always_ff @(posedge clk) begin
    if (i_op == FETCH_DONE || i_op == LOAD_DONE)
        tag_q <= i_tag;
end

assign tag = mem_tag_t'(tag_q);

// ----------------------------------------
// Checks in priority order
always_comb begin
    hit  = 1'b1;
    vect = INT_NONE;
    if (fetch_q && tag.pint && !i_mode.no_progtag)
        vect = INT_PINT_CMD;                        // Program tag on instruction
    else if (load_q && tag.pint && !i_mode.no_progtag)
        vect = INT_PINT_OPND;                       // Program tag on operand
    else if (load_q && tag.noload && !i_mode.no_rtag)
        vect = INT_RD_PROT;                         // Read-protected operand
    else if (fetch_q && !tag.cmd)
        vect = INT_CMD_CHECK;                       // Not an instruction word
    else if (fetch_q && tag.nofetch)
        vect = INT_FETCH_PROT;
    else if (fetch_q && tag.nojump && i_mode.flag_jump)
        vect = INT_JUMP_PROT;                       // Jump onto forbidden word
    else if (fetch_q && (tag.besm6 != i_acc_besm6) && !i_mode.no_badacc)
        vect = INT_BAD_ACC;                         // Foreign accumulator
    else if (load_q && (tag.besm6 != i_acc_besm6) && !i_mode.no_badop)
        vect = INT_BAD_OPND;                        // Foreign operand
    else
        hit = 1'b0;
end

// ----------------------------------------
// Stage 2, interrupt flag and vector
always_ff @(posedge clk) begin
    if (reset) begin
        o_int      <= 1'b0;
        o_int_vect <= INT_NONE;
    end else if (hit) begin
        o_int      <= 1'b1;
        o_int_vect <= vect;         // Latest event overwrites
    end else if (i_op == CLEAR_INT) begin
        o_int <= 1'b0;              // Vector is kept
    end
end

a_vect_listed: assert property (@(posedge clk) disable iff (reset)
    o_int |-> o_int_vect inside {INT_PINT_CMD, INT_PINT_OPND, INT_RD_PROT,
                                 INT_CMD_CHECK, INT_FETCH_PROT, INT_JUMP_PROT,
                                 INT_BAD_ACC, INT_BAD_OPND})
    else $error("interrupt raised with unlisted vector %0d", o_int_vect);

endmodule

//--- logic/page_translate.sv
// Effective-address register, page map, address translation
// and used/dirty bits of physical pages

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module page_translate
    import mbesm_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    input  mmu_op_t                                 i_op,
    input  arb_op_t                                 i_arb_op,
    input  logic [`MBESM_VADDR_W-1:0]               i_data,
    input  logic                                    i_no_paging,
    input  logic                                    i_mode_besm6,
    output logic [`MBESM_PAGE_W+`MBESM_OFFS_W-1:0]  o_physad,
    output logic [`MBESM_MAP_W-1:0]                 o_map_rdata,
    output page_access_t                            o_access
);

logic [`MBESM_VADDR_W-1:0] vaddr;                   // Effective address
logic [`MBESM_MAP_W-1:0]   pg_map [`MBESM_PAGES];   // Page map
logic                      pg_used [`MBESM_PAGES];  // Referenced bits
logic                      pg_dirty [`MBESM_PAGES]; // Modified bits
logic [`MBESM_PAGE_W-1:0]  pg_index;                // Physical page register
logic [`MBESM_PAGE_W-1:0]  map_idx;                 // Map slot of vaddr
logic [`MBESM_PAGE_W-1:0]  pg_virt;                 // Virtual page
logic [`MBESM_PAGE_W-1:0]  pg_phys;                 // Translated page
logic                      arb_write;               // Write-class bus op

// ----------------------------------------
// Translation
assign map_idx = vaddr[`MBESM_OFFS_W +: `MBESM_PAGE_W];

assign pg_virt = i_mode_besm6
    ? {{(`MBESM_PAGE_W-`MBESM_BESM6_PAGE_W){1'b0}},
       vaddr[`MBESM_OFFS_W +: `MBESM_BESM6_PAGE_W]}    // 15-bit BESM-6 space
    : map_idx;                                          // 20-bit native space

assign pg_phys = i_no_paging ? pg_virt
                             : pg_map[pg_virt][`MBESM_MAP_W-1 -: `MBESM_PAGE_W];

assign o_physad    = {pg_phys, vaddr[`MBESM_OFFS_W-1:0]};
assign o_map_rdata = pg_map[map_idx];
assign o_access    = {pg_dirty[pg_index], pg_used[pg_index]};

// Arbiter codes that modify memory
always_comb begin
    case (i_arb_op)
        CCWR, DCWR, DWR, RDMWR, BTRWR: arb_write = 1'b1;
        default:                       arb_write = 1'b0;
    endcase
end

// ----------------------------------------
// Address and physical-page registers
always_ff @(posedge clk) begin
    if (reset) begin
        vaddr    <= '0;
        pg_index <= '0;
    end else begin
        if (i_op == LOAD_VADDR)
            vaddr <= i_data;
        if (i_op == BUS_REQ)
            pg_index <= pg_phys;    // Page of this bus cycle
    end
end

// Page map write
always_ff @(posedge clk) begin
    if (i_op == WRITE_MAP)
        pg_map[map_idx] <= i_data[`MBESM_MAP_W-1:0];
end

// Used and dirty bits
always_ff @(posedge clk) begin
    case (i_op)
        BUS_REQ: begin
            pg_used[pg_phys] <= 1'b1;       // Any access references the page
            if (arb_write)
                pg_dirty[pg_phys] <= 1'b1;
        end
        WRITE_ACCESS: begin
            pg_used[pg_index]  <= i_data[1];
            pg_dirty[pg_index] <= i_data[2];
        end
        default: ;
    endcase
end

// Controller must give a real arbiter code with every bus request
a_arb_op_defined: assert property (@(posedge clk) disable iff (reset)
    (i_op == BUS_REQ) |-> (!$isunknown(i_arb_op) && i_arb_op <= BTRRD))
    else $error("BUS_REQ with undefined arbiter op %0h", i_arb_op);

endmodule

//--- logic/mode_reg.sv
// Mode register, emulation-mode flag and accumulator emulation tag

`timescale 1ns/100ps
`include "mbesm_cfg.svh"

module mode_reg
    import mbesm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  mmu_op_t                   i_op,
    input  logic [`MBESM_VADDR_W-1:0] i_data,
    input  mem_tag_t                  i_tag,        // Tag of the fetched word
    output mode_reg_t                 o_mode,
    output logic                      o_mode_besm6, // Emulation mode
    output logic                      o_acc_besm6   // Accumulator tag bit
);

// ----------------------------------------
// Mode register
always_ff @(posedge clk) begin
    if (reset)
        o_mode <= '0;
    else if (i_op == LOAD_RR)
        o_mode <= mode_reg_t'(i_data);  // Whole register at once
end

// ----------------------------------------
// Emulation mode follows the fetched tag before SET_ER/SET_NR
always_ff @(posedge clk) begin
    if (reset)
        o_mode_besm6 <= 1'b0;
    else if (i_op == FETCH_DONE)
        o_mode_besm6 <= i_tag.besm6;    // Follow the instruction word
    else if (i_op == SET_ER)
        o_mode_besm6 <= 1'b1;
    else if (i_op == SET_NR)
        o_mode_besm6 <= 1'b0;
end

// Accumulator emulation tag
always_ff @(posedge clk) begin
    if (reset)
        o_acc_besm6 <= 1'b0;
    else if (i_op == LOAD_ACC_TAG)
        o_acc_besm6 <= i_data[1];       // Besm6 bit position of a tag
end

// Virtual page selection depends on this flag
a_mode_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(o_mode_besm6))
    else $error("mode_besm6 is unknown");

endmodule

//--- logic/mbesm_pkg.sv
// Shared types: operation codes, arbiter codes, mode register,
// memory tag, interrupt vectors and page access bits
package mbesm_pkg;

// Operations strobed by the outside controller
typedef enum logic [3:0] {
    NOP          = 4'd0,
    LOAD_RR      = 4'd1,    // Mode register from data
    LOAD_VADDR   = 4'd2,    // Effective address from data
    WRITE_MAP    = 4'd3,    // Page map entry from data
    BUS_REQ      = 4'd4,    // Bus request, updates used/dirty
    WRITE_ACCESS = 4'd5,    // Explicit used/dirty write
    FETCH_DONE   = 4'd6,    // Instruction fetch complete
    LOAD_DONE    = 4'd7,    // Operand load complete
    SET_NR       = 4'd8,    // Native mode
    SET_ER       = 4'd9,    // Emulation mode
    LOAD_ACC_TAG = 4'd10,   // Accumulator tag from data
    CLEAR_INT    = 4'd11    // Drop interrupt flag
} mmu_op_t;

// Arbiter operations, write class is CCWR/DCWR/DWR/RDMWR/BTRWR
typedef enum logic [3:0] {
    ARB_IDLE = 4'd0,  CCRD  = 4'd1,  CCWR  = 4'd2,  DCRD  = 4'd3,
    DCWR     = 4'd4,  CRD   = 4'd5,  IRD   = 4'd6,  BRD   = 4'd7,
    DRD      = 4'd8,  RMWRD = 4'd9,  DWR   = 4'd10, RDMWR = 4'd11,
    BTRWR    = 4'd12, BTRRD = 4'd13
} arb_op_t;

// Mode register, bit 31 down to bit 0
typedef struct packed {
    logic [1:0] unused;         // Bits 31:30, not assigned
    logic       flag_jump;      // Control transfer flag
    logic       rcb;            // Right command flag
    logic       cb;             // Address changed by register 16
    logic       no_paging;      // Page translation off
    logic       no_procnm;      // Process number check off
    logic       flag_negaddr;   // Negative address mode
    logic       no_rprot;       // Access protection off
    logic       no_wprot;       // Write protection off
    logic       intstp;         // Stop on interrupt
    logic       single_step;    // Step-by-step execution
    logic       cemlrg;         // Reserved
    logic       wforce;         // Store tag check off
    logic       no_intr;        // External interrupts masked
    logic       no_progtag;     // Program tag interpretation off
    logic       no_badacc;      // Foreign accumulator check off
    logic       no_rtag;        // Operand read tag check off
    logic       no_badop;       // Foreign operand check off
    logic       drg;            // Dispatcher mode
    logic       ovrftb;         // Stash field overflow check off
    logic       bnb;            // BESM-6 range check off
    logic       flag_z, flag_n, flag_c, flag_v; // Condition flags
    logic       ovrib;          // Overflow interrupt off
    logic [2:0] grp;            // Condition group
    logic       rndb;           // Rounding off
    logic       normb;          // Normalization off
} mode_reg_t;

// Memory word tag
typedef struct packed {
    logic pint;                 // Program tag interpretation
    logic spare;
    logic nojump;               // No control transfer here
    logic nofetch;              // No instruction fetch
    logic nostore;              // No operand store
    logic noload;               // No operand load
    logic besm6;                // Emulation-mode word
    logic cmd;                  // Instruction word
} mem_tag_t;

// Interrupt vectors raised by the tag checks
typedef enum logic [4:0] {
    INT_NONE       = 5'd0,
    INT_PINT_CMD   = 5'd9,
    INT_PINT_OPND  = 5'd10,
    INT_RD_PROT    = 5'd11,
    INT_CMD_CHECK  = 5'd12,
    INT_FETCH_PROT = 5'd18,
    INT_JUMP_PROT  = 5'd19,
    INT_BAD_ACC    = 5'd21,
    INT_BAD_OPND   = 5'd22
} int_vect_t;

// Access bits of one physical page
typedef struct packed {
    logic dirty;                // Page was modified
    logic used;                 // Page was referenced
} page_access_t;

endpackage

//--- logic/mbesm_cfg.svh
// Size definitions for the page map, addresses and memory tags
`ifndef MBESM_CFG_SVH
`define MBESM_CFG_SVH

// Page map
`define MBESM_PAGES         1024    // Entries in the page map
`define MBESM_PAGE_W        10      // Page number width
`define MBESM_OFFS_W        10      // In-page offset width
`define MBESM_MAP_W         20      // Map entry, physical page in upper bits

// Addresses
`define MBESM_VADDR_W       32      // Effective address register
`define MBESM_BESM6_PAGE_W  5       // Virtual page in BESM-6 emulation

// Tags
`define MBESM_TAG_W         8       // Memory word tag

`endif
